// File: cache_ctrl.sv
// cache controller: tag compare, victim choice, byte merge, metadata update and forwarding
module cache_ctrl import cache_geom_pkg::*, cache_op_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               req_valid_i,
    input  cache_op_e          req_op_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic [DATA_W-1:0]  req_wdata_i,
    input  logic [STRB_W-1:0]  req_wstrb_i,
    input  logic               init_done_i,
    input  meta_byte_t         meta_rd_i,
    output logic               rsp_valid_o,
    output logic               rsp_hit_o,
    output way_sel_t           rsp_way_o,
    output logic [DATA_W-1:0]  rsp_rdata_o,
    output logic               evict_o,
    output logic [ADDR_W-1:0]  evict_addr_o,
    output logic [DATA_W-1:0]  evict_data_o,
    output logic               meta_rd_en_o,
    output logic [INDEX_W-1:0] meta_rd_index_o,
    output logic               meta_wr_en_o,
    output logic [INDEX_W-1:0] meta_wr_index_o,
    output meta_byte_t         meta_wr_o,
    cache_way_if.ctrl_mp       way0,
    cache_way_if.ctrl_mp       way1
);

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    cache_addr_t              req_addr;
    logic                     req_take;
    logic                     s1_valid;
    cache_op_e                s1_op;
    cache_addr_t              s1_addr;
    logic [DATA_W-1:0]        s1_wdata;
    logic [STRB_W-1:0]        s1_wstrb;
    logic                     cm_valid;   // last commit, kept for a same-index follower
    logic [INDEX_W-1:0]       cm_index;
    meta_byte_t               cm_meta;
    logic [1:0][TAG_W-1:0]    cm_tag;
    logic [1:0][DATA_W-1:0]   cm_data;
    logic                     fwd;
    meta_byte_t               eff_meta;
    logic [1:0][TAG_W-1:0]    eff_tag;
    logic [1:0][DATA_W-1:0]   eff_data;
    logic [1:0]               hit;
    logic [1:0]               vld;
    logic [1:0]               dty;
    logic [1:0]               new_vld;
    logic [1:0]               new_dty;
    logic                     new_lru;
    way_sel_t                 hit_way;
    way_sel_t                 tgt_way;
    logic [1:0]               way_we;
    logic [STRB_W-1:0]        wr_strb;
    meta_byte_t               new_meta;
    logic [1:0][TAG_W-1:0]    new_tag;
    logic [1:0][DATA_W-1:0]   new_data;
    logic                     rsp_hit;
    way_sel_t                 rsp_way;
    logic [DATA_W-1:0]        rsp_data;
    logic                     evict;
    cache_addr_t              ev_addr;

    assign req_addr = req_addr_i;
    assign req_take = req_valid_i & init_done_i;   // nothing is accepted during the clear sweep

    // stage 0 reads both ways and the metadata byte at the request edge
    assign way0.en         = req_take;
    assign way1.en         = req_take;
    assign way0.index      = req_addr.f.index;
    assign way1.index      = req_addr.f.index;
    assign meta_rd_en_o    = req_take;
    assign meta_rd_index_o = req_addr.f.index;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_take;
        end
    end

    always_ff @(posedge clk) begin
        s1_op    <= req_op_i;
        s1_addr  <= req_addr;
        s1_wdata <= req_wdata_i;
        s1_wstrb <= req_wstrb_i;
    end

    always_comb begin
        // arrays read at the commit edge miss that commit
        fwd         = cm_valid & (cm_index == s1_addr.f.index);
        eff_meta    = fwd ? cm_meta : meta_rd_i;
        eff_tag[0]  = fwd ? cm_tag[0] : way0.rtag;
        eff_tag[1]  = fwd ? cm_tag[1] : way1.rtag;
        eff_data[0] = fwd ? cm_data[0] : way0.rdata;
        eff_data[1] = fwd ? cm_data[1] : way1.rdata;

        vld = {eff_meta.f.w1_valid, eff_meta.f.w0_valid};
        dty = {eff_meta.f.w1_dirty, eff_meta.f.w0_dirty};
        hit[0]  = vld[0] & (eff_tag[0] == s1_addr.f.tag);
        hit[1]  = vld[1] & (eff_tag[1] == s1_addr.f.tag);
        hit_way = way_sel_t'(hit[1]);

        if (|hit) begin
            tgt_way = hit_way;          // a refill of a present tag stays in place
        end else if (!vld[0]) begin
            tgt_way = 1'b0;
        end else if (!vld[1]) begin
            tgt_way = 1'b1;
        end else begin
            tgt_way = eff_meta.f.lru;
        end

        way_we   = '0;
        wr_strb  = s1_wstrb;
        new_vld  = vld;
        new_dty  = dty;
        new_lru  = eff_meta.f.lru;
        rsp_hit  = |hit;
        rsp_way  = 1'b0;
        rsp_data = '0;
        evict    = 1'b0;

        case (s1_op)
            OP_READ: begin
                if (|hit) begin
                    rsp_way  = hit_way;
                    rsp_data = eff_data[hit_way];
                    new_lru  = ~hit_way;
                end
            end
            OP_WRITE: begin
                if (|hit) begin
                    way_we[hit_way]  = 1'b1;
                    new_dty[hit_way] = 1'b1;
                    rsp_way          = hit_way;
                    new_lru          = ~hit_way;
                end
            end
            OP_FILL: begin
                way_we[tgt_way]  = 1'b1;
                wr_strb          = '1;
                new_vld[tgt_way] = 1'b1;
                new_dty[tgt_way] = 1'b0;
                rsp_way          = tgt_way;
                new_lru          = ~tgt_way;
                evict            = ~(|hit) & vld[tgt_way] & dty[tgt_way];
            end
            default: ;
        endcase
        way_we = way_we & {2{s1_valid}};

        // only the touched way's bits and the LRU bit change
        new_meta            = eff_meta;
        new_meta.f.w0_valid = new_vld[0];
        new_meta.f.w0_dirty = new_dty[0];
        new_meta.f.w1_valid = new_vld[1];
        new_meta.f.w1_dirty = new_dty[1];
        new_meta.f.lru      = new_lru;

        for (int w = 0; w < 2; w++) begin
            new_tag[w]  = way_we[w] ? s1_addr.f.tag : eff_tag[w];
            new_data[w] = way_we[w] ? merge_bytes(eff_data[w], s1_wdata, wr_strb) : eff_data[w];
        end

        ev_addr          = '0;
        ev_addr.f.tag    = eff_tag[tgt_way];
        ev_addr.f.index  = s1_addr.f.index;
    end

    assign way0.we     = way_we[0];
    assign way1.we     = way_we[1];
    assign way0.wstrb  = wr_strb;
    assign way1.wstrb  = wr_strb;
    assign way0.wtag   = s1_addr.f.tag;
    assign way1.wtag   = s1_addr.f.tag;
    assign way0.wdata  = s1_wdata;
    assign way1.wdata  = s1_wdata;

    assign meta_wr_en_o    = s1_valid;
    assign meta_wr_index_o = s1_addr.f.index;
    assign meta_wr_o       = new_meta;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            evict_o     <= 1'b0;
            cm_valid    <= 1'b0;
        end else begin
            rsp_valid_o <= s1_valid;
            evict_o     <= s1_valid & evict;
            cm_valid    <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_hit_o    <= rsp_hit;
        rsp_way_o    <= rsp_way;
        rsp_rdata_o  <= rsp_data;
        evict_addr_o <= ev_addr.raw;
        evict_data_o <= eff_data[tgt_way];
        cm_index     <= s1_addr.f.index;
        cm_meta      <= new_meta;
        cm_tag       <= new_tag;
        cm_data      <= new_data;
    end

endmodule

// File: cache_geom_pkg.sv
// cache geometry: address split, array widths and the packed metadata byte
package cache_geom_pkg;

    localparam int TAG_W    = 8;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 2;
    localparam int ADDR_W   = 18;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = 4;
    localparam int SETS     = 256;

    // byte address seen either as one word or as tag, set index and byte offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } cache_addr_t;

    // one metadata byte per set, shared by both ways
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic w1_spare;   // reserved for a ninth tag bit of way 1
            logic w1_dirty;
            logic w1_valid;
            logic spare;
            logic lru;        // names the way to replace next
            logic w0_spare;   // reserved for a ninth tag bit of way 0
            logic w0_dirty;
            logic w0_valid;
        } f;
    } meta_byte_t;

endpackage

// File: cache_meta.sv
// cache metadata RAM: valid, dirty and LRU byte per set, cleared by a sweep after reset
module cache_meta import cache_geom_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               rd_en_i,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  logic               wr_en_i,
    input  logic [INDEX_W-1:0] wr_index_i,
    input  meta_byte_t         wr_byte_i,
    output meta_byte_t         rd_byte_o,
    output logic               init_done_o
);

    logic [7:0]         mem [SETS];
    logic [INDEX_W-1:0] sweep_idx;
    logic               sweeping;
    logic               wr_en;
    logic [INDEX_W-1:0] wr_index;
    meta_byte_t         wr_byte;

    assign sweeping = ~init_done_o;

    // one entry per cycle from the first edge after reset release
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sweep_idx   <= '0;
            init_done_o <= 1'b0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == INDEX_W'(SETS - 1)) begin
                init_done_o <= 1'b1;   // last entry is written at this edge
            end
        end
    end

    // the sweep takes the write port away from the controller
    always_comb begin
        wr_en    = wr_en_i;
        wr_index = wr_index_i;
        wr_byte  = wr_byte_i;
        if (sweeping) begin
            wr_en       = 1'b1;
            wr_index    = sweep_idx;
            wr_byte.raw = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_byte.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_byte_o.raw <= mem[rd_index_i];   // old byte on a same-index write
        end
    end

endmodule

// File: cache_op_pkg.sv
// cache command encoding and way number shared across the cache store
package cache_op_pkg;

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,   // hit only, a miss leaves the set alone
        OP_FILL  = 2'd2
    } cache_op_e;

    typedef logic way_sel_t;   // two ways, so one bit

endpackage

// File: cache_stim.txt
# name op addr wdata wstrb | expected: hit way rdata evict evict_addr evict_data (all hex)
# op 0 read, 1 write, 2 fill; addr is tag[17:10] index[9:2] offset[1:0]
rd_empty     0 04414 00000000 0 0 0 00000000 0 00000 00000000
fill_a       2 04414 a0a1a2a3 f 0 0 00000000 0 00000 00000000
rd_a         0 04414 00000000 0 1 0 a0a1a2a3 0 00000 00000000
fill_b       2 08814 b0b1b2b3 f 0 1 00000000 0 00000 00000000
rd_b         0 08814 00000000 0 1 1 b0b1b2b3 0 00000 00000000
wr_a         1 04414 55667788 5 1 0 00000000 0 00000 00000000
rd_a2        0 04414 00000000 0 1 0 a066a288 0 00000 00000000
wr_miss      1 0cc14 ffffffff f 0 0 00000000 0 00000 00000000
rd_b2        0 08814 00000000 0 1 1 b0b1b2b3 0 00000 00000000
fill_c       2 0cc14 c0c1c2c3 f 0 0 00000000 1 04414 a066a288
rd_c         0 0cc14 00000000 0 1 0 c0c1c2c3 0 00000 00000000
rd_a_gone    0 04414 00000000 0 0 0 00000000 0 00000 00000000
wr_b         1 08814 12345678 c 1 1 00000000 0 00000 00000000
fill_b_again 2 08814 beef0001 f 1 1 00000000 0 00000 00000000
rd_b3        0 08814 00000000 0 1 1 beef0001 0 00000 00000000
rd_c2        0 0cc14 00000000 0 1 0 c0c1c2c3 0 00000 00000000
fill_d       2 11014 d0d1d2d3 f 0 1 00000000 0 00000 00000000
rd_d         0 11014 00000000 0 1 1 d0d1d2d3 0 00000 00000000
rd_b_gone    0 08814 00000000 0 0 0 00000000 0 00000 00000000
fill_e       2 004fc 0e0e0e0e f 0 0 00000000 0 00000 00000000
fill_f       2 008fc 0f0f0f0f f 0 1 00000000 0 00000 00000000
wr_e         1 004fd aabbccdd 2 1 0 00000000 0 00000 00000000
wr_f         1 008fe 11223344 9 1 1 00000000 0 00000 00000000
fill_g       2 00cfc 33333333 f 0 0 00000000 1 004fc 0e0ecc0e
fill_h       2 010fc 44444444 f 0 1 00000000 1 008fc 110f0f44
rd_g         0 00cfc 00000000 0 1 0 33333333 0 00000 00000000
rd_h         0 010ff 00000000 0 1 1 44444444 0 00000 00000000
rd_c3        0 0cc14 00000000 0 1 0 c0c1c2c3 0 00000 00000000
rd_far       0 3fffc 00000000 0 0 0 00000000 0 00000 00000000
wr_g         1 00cfc cafef00d f 1 0 00000000 0 00000 00000000
rd_g2        0 00cfc 00000000 0 1 0 cafef00d 0 00000 00000000
fill_g_again 2 00cfc 01020304 f 1 0 00000000 0 00000 00000000
fill_i       2 014fc 55555555 f 0 1 00000000 0 00000 00000000
fill_j       2 018fc 66666666 f 0 0 00000000 0 00000 00000000
rd_g_gone    0 00cfc 00000000 0 0 0 00000000 0 00000 00000000
rd_j         0 018fc 00000000 0 1 0 66666666 0 00000 00000000
rd_i         0 014fc 00000000 0 1 1 55555555 0 00000 00000000

// File: cache_store.f
cache_geom_pkg.sv
cache_op_pkg.sv
cache_way_if.sv
cache_way.sv
cache_meta.sv
cache_ctrl.sv
cache_top.sv
tb_cache_top.sv

// File: cache_top.sv
// two-way L1 cache store: controller, two tag/data ways and the shared metadata RAM
module cache_top import cache_geom_pkg::*, cache_op_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  cache_op_e         req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    input  logic [STRB_W-1:0] req_wstrb_i,
    output logic              rsp_valid_o,
    output logic              rsp_hit_o,
    output way_sel_t          rsp_way_o,
    output logic [DATA_W-1:0] rsp_rdata_o,
    output logic              evict_o,
    output logic [ADDR_W-1:0] evict_addr_o,
    output logic [DATA_W-1:0] evict_data_o,
    output logic              init_done_o
);

    logic               meta_rd_en;
    logic [INDEX_W-1:0] meta_rd_index;
    logic               meta_wr_en;
    logic [INDEX_W-1:0] meta_wr_index;
    meta_byte_t         meta_wr_byte;
    meta_byte_t         meta_rd_byte;

    cache_way_if way0_bus ();
    cache_way_if way1_bus ();

    cache_ctrl ctrl_u (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_wstrb_i     (req_wstrb_i),
        .init_done_i     (init_done_o),
        .meta_rd_i       (meta_rd_byte),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_hit_o       (rsp_hit_o),
        .rsp_way_o       (rsp_way_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .evict_o         (evict_o),
        .evict_addr_o    (evict_addr_o),
        .evict_data_o    (evict_data_o),
        .meta_rd_en_o    (meta_rd_en),
        .meta_rd_index_o (meta_rd_index),
        .meta_wr_en_o    (meta_wr_en),
        .meta_wr_index_o (meta_wr_index),
        .meta_wr_o       (meta_wr_byte),
        .way0            (way0_bus.ctrl_mp),
        .way1            (way1_bus.ctrl_mp)
    );

    cache_way way0_u (
        .clk (clk),
        .bus (way0_bus.array_mp)
    );

    cache_way way1_u (
        .clk (clk),
        .bus (way1_bus.array_mp)
    );

    cache_meta meta_u (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rd_en_i     (meta_rd_en),
        .rd_index_i  (meta_rd_index),
        .wr_en_i     (meta_wr_en),
        .wr_index_i  (meta_wr_index),
        .wr_byte_i   (meta_wr_byte),
        .rd_byte_o   (meta_rd_byte),
        .init_done_o (init_done_o)
    );

endmodule

// File: cache_way.sv
// cache way: 256-entry tag array and byte-writable data array with synchronous read
module cache_way import cache_geom_pkg::*; (
    input logic           clk,
    cache_way_if.array_mp bus
);

    logic [TAG_W-1:0]   tag_mem  [SETS];
    logic [DATA_W-1:0]  data_mem [SETS];
    logic [INDEX_W-1:0] wr_index;   // set of the last read, which the commit writes back to

    // read data holds while en is low, like the SRAM macros
    always_ff @(posedge clk) begin
        if (bus.en) begin
            wr_index  <= bus.index;
            bus.rtag  <= tag_mem[bus.index];    // read-first against a same-edge write
            bus.rdata <= data_mem[bus.index];
        end
    end

    always_ff @(posedge clk) begin
        if (bus.we) begin
            tag_mem[wr_index] <= bus.wtag;
            for (int b = 0; b < STRB_W; b++) begin
                if (bus.wstrb[b]) begin
                    data_mem[wr_index][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: cache_way_if.sv
// cache way port: read and byte-masked write access to one way's tag and data arrays
interface cache_way_if import cache_geom_pkg::*; ();

    logic               en;      // read strobe, also latches the index for the next write
    logic [INDEX_W-1:0] index;
    logic               we;
    logic [STRB_W-1:0]  wstrb;
    logic [TAG_W-1:0]   wtag;
    logic [DATA_W-1:0]  wdata;
    logic [TAG_W-1:0]   rtag;
    logic [DATA_W-1:0]  rdata;

    // a write always belongs to the request whose read was issued one edge earlier
    modport ctrl_mp (
        output en, index, we, wstrb, wtag, wdata,
        input  rtag, rdata
    );

    modport array_mp (
        input  en, index, we, wstrb, wtag, wdata,
        output rtag, rdata
    );

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# builds the cache store testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_cache_top -f cache_store.f \
    -o sim_cache_store &&
./obj_dir/sim_cache_store | tee /dev/stderr | grep -qx "SIMULATION PASSED" &&
echo "run_sim: testbench reported success" ||
{ echo "run_sim: build or simulation failed"; exit 1; }

// File: tb_cache_top.sv
// cache store testbench: replays the stim file with random idle gaps and checks every response
module tb_cache_top import cache_geom_pkg::*, cache_op_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 16;
    localparam int SEED       = 75;
    localparam     STIM_FILE  = "cache_stim.txt";

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              req_valid_i;
    cache_op_e         req_op_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic [STRB_W-1:0] req_wstrb_i;
    logic              rsp_valid_o;
    logic              rsp_hit_o;
    way_sel_t          rsp_way_o;
    logic [DATA_W-1:0] rsp_rdata_o;
    logic              evict_o;
    logic [ADDR_W-1:0] evict_addr_o;
    logic [DATA_W-1:0] evict_data_o;
    logic              init_done_o;

    // one entry per stim line
    logic [8*16-1:0]   t_name   [$];
    logic [1:0]        t_op     [$];
    cache_addr_t       t_addr   [$];
    logic [DATA_W-1:0] t_wdata  [$];
    logic [STRB_W-1:0] t_wstrb  [$];
    logic              t_hit    [$];
    way_sel_t          t_way    [$];
    logic [DATA_W-1:0] t_rdata  [$];
    logic              t_ev     [$];
    cache_addr_t       t_evaddr [$];
    logic [DATA_W-1:0] t_evdata [$];
    int                pend_q   [$];   // stim lines still waiting for their response
    int                n_lines     = 0;
    logic              stim_loaded = 1'b0;
    int                rsp_idx;
    int                gap;

    cache_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input string test, input string field, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("MISMATCH %0s %0s: expected %0b, actual %0b", test, field, exp, act);
            fail_run();
        end
    endtask

    task automatic check_way(input string test, input way_sel_t exp, input way_sel_t act);
        if (act !== exp) begin
            $display("MISMATCH %0s way: expected %0d, actual %0d", test, exp, act);
            fail_run();
        end
    endtask

    task automatic check_data(input string test, input string field,
                              input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %0s %0s: expected %h, actual %h", test, field, exp, act);
            fail_run();
        end
    endtask

    task automatic check_addr(input string test, input cache_addr_t exp, input cache_addr_t act);
        if (act.raw !== exp.raw) begin
            $display(
                "MISMATCH %0s evict_addr: expected %h (tag %h idx %h), actual %h (tag %h idx %h)",
                test, exp.raw, exp.f.tag, exp.f.index, act.raw, act.f.tag, act.f.index);
            fail_run();
        end
    endtask

    task automatic load_stim();
        int                fd;
        int                code;
        string             line;
        logic [8*16-1:0]   name;
        logic [1:0]        op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              hit;
        logic              way;
        logic [DATA_W-1:0] rdata;
        logic              ev;
        logic [ADDR_W-1:0] ev_addr;
        logic [DATA_W-1:0] ev_data;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %0s", STIM_FILE);
            fail_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;   // column header or blank
                code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, op, addr, wdata,
                               wstrb, hit, way, rdata, ev, ev_addr, ev_data);
                if (code != 11) begin
                    $display("stimulus line has %0d fields instead of 11: %0s", code, line);
                    fail_run();
                end else begin
                    t_name.push_back(name);
                    t_op.push_back(op);
                    t_addr.push_back(addr);
                    t_wdata.push_back(wdata);
                    t_wstrb.push_back(wstrb);
                    t_hit.push_back(hit);
                    t_way.push_back(way);
                    t_rdata.push_back(rdata);
                    t_ev.push_back(ev);
                    t_evaddr.push_back(ev_addr);
                    t_evdata.push_back(ev_data);
                end
            end
            $fclose(fd);
            n_lines = t_name.size();
        end
    endtask

    task automatic drive_idle();
        req_valid_i = 1'b0;
        req_op_i    = OP_READ;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_wstrb_i = '0;
    endtask

    task automatic drive_request(input int i);
        req_valid_i = 1'b1;
        req_op_i    = cache_op_e'(t_op[i]);
        req_addr_i  = t_addr[i].raw;
        req_wdata_i = t_wdata[i];
        req_wstrb_i = t_wstrb[i];
        pend_q.push_back(i);
    endtask

    task automatic check_response(input int i);
        string test;
        test = $sformatf("%0s", t_name[i]);
        check_bit(test, "hit", t_hit[i], rsp_hit_o);
        check_way(test, t_way[i], rsp_way_o);
        check_data(test, "rdata", t_rdata[i], rsp_rdata_o);
        check_bit(test, "evict", t_ev[i], evict_o);
        if (t_ev[i]) begin   // victim fields only mean something with the strobe
            check_addr(test, t_evaddr[i], evict_addr_o);
            check_data(test, "evict_data", t_evdata[i], evict_data_o);
        end
    endtask

    // outputs change on the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (rsp_valid_o) begin
            if (pend_q.size() == 0) begin
                $display("a response arrived with no request outstanding");
                fail_run();
            end else begin
                rsp_idx = pend_q.pop_front();
                check_response(rsp_idx);
            end
        end else if (evict_o) begin
            $display("evict_o went high without a response");
            fail_run();
        end
    end

    initial begin
        wait (stim_loaded);
        repeat (n_lines * 4 + 300) @(posedge clk);   // sweep, latency and the longest gaps fit
        if (pend_q.size() != 0) begin
            $display("watchdog timeout with %0d responses missing", pend_q.size());
            fail_run();
        end else begin
            $display("watchdog timeout before the last request was sent");
            fail_run();
        end
    end

    initial begin
        rst_n_i = 1'b0;
        drive_idle();
        void'($urandom(SEED));
        load_stim();
        stim_loaded = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        check_bit("reset", "rsp_valid", 1'b0, rsp_valid_o);
        check_bit("reset", "evict", 1'b0, evict_o);
        check_bit("reset", "init_done", 1'b0, init_done_o);
        rst_n_i = 1'b1;
        // a request during the clear sweep is dropped and must not answer
        req_valid_i = 1'b1;
        req_op_i    = OP_FILL;
        req_addr_i  = 18'h3fffc;
        req_wstrb_i = '1;
        repeat (4) @(negedge clk);
        drive_idle();
        while (!init_done_o) @(negedge clk);
        for (int i = 0; i < n_lines; i++) begin
            @(negedge clk);
            drive_request(i);
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(negedge clk);
                drive_idle();
            end
        end
        @(negedge clk);
        drive_idle();
        while (pend_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);   // leaves room for a stray extra response
        if (n_lines > 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("the stimulus file held no commands");
            fail_run();
        end
    end

endmodule
